/* Bender.yml */
package:
  name: awsf1_cl_stat

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/cl_stat_pkg.sv
      - design/stat_pipe.sv
      - design/cl_reset_sync.sv
      - design/stat_reg_target.sv
      - design/stat_channel.sv
      - design/awsf1_cl_stat.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_awsf1_cl_stat.sv

/* design/awsf1_cl_stat.sv */
`timescale 1ns/1ps

`include "cl_stat_config.svh"

module awsf1_cl_stat
(
  input  logic                     clk_main_a0,
  input  logic                     pipe_rst_n,

  // channel A
  input  logic                     stat_wr_0,
  input  logic                     stat_rd_0,
  input  cl_stat_pkg::stat_addr_u  stat_addr_0,
  input  logic [`STAT_DATA_W-1:0]  stat_wdata_0,
  output logic                     stat_ack_0,
  output logic [`STAT_DATA_W-1:0]  stat_rdata_0,
  output logic [`STAT_INT_W-1:0]   stat_int_0,

  // channel B
  input  logic                     stat_wr_1,
  input  logic                     stat_rd_1,
  input  cl_stat_pkg::stat_addr_u  stat_addr_1,
  input  logic [`STAT_DATA_W-1:0]  stat_wdata_1,
  output logic                     stat_ack_1,
  output logic [`STAT_DATA_W-1:0]  stat_rdata_1,
  output logic [`STAT_INT_W-1:0]   stat_int_1,

  // channel D is never built
  input  logic                     stat_wr_2,
  input  logic                     stat_rd_2,
  input  cl_stat_pkg::stat_addr_u  stat_addr_2,
  input  logic [`STAT_DATA_W-1:0]  stat_wdata_2,
  output logic                     stat_ack_2,
  output logic [`STAT_DATA_W-1:0]  stat_rdata_2,
  output logic [`STAT_INT_W-1:0]   stat_int_2
);

  logic sync_rst_n;   // pipes
  logic chan_rst_n;   // register blocks a few cycles later

  // ----------------------------------------------------------------------------
  // reset conditioning
  // ----------------------------------------------------------------------------
  cl_reset_sync u_reset_sync
  (
    .clk        (clk_main_a0),
    .pipe_rst_n (pipe_rst_n),
    .sync_rst_n (sync_rst_n),
    .chan_rst_n (chan_rst_n)
  );

  // ----------------------------------------------------------------------------
  // channel A is always present
  // ----------------------------------------------------------------------------
  stat_channel #(.CHANNEL(0)) u_chan_a
  (
    .clk        (clk_main_a0),
    .sync_rst_n (sync_rst_n),
    .chan_rst_n (chan_rst_n),
    .stat_wr    (stat_wr_0),
    .stat_rd    (stat_rd_0),
    .stat_addr  (stat_addr_0),
    .stat_wdata (stat_wdata_0),
    .stat_ack   (stat_ack_0),
    .stat_rdata (stat_rdata_0),
    .stat_int   (stat_int_0)
  );

  // ----------------------------------------------------------------------------
  // channel B is optional
  // ----------------------------------------------------------------------------
  if (`DDR_B_PRESENT)
  begin : g_chan_b
    stat_channel #(.CHANNEL(1)) u_chan_b
    (
      .clk        (clk_main_a0),
      .sync_rst_n (sync_rst_n),
      .chan_rst_n (chan_rst_n),
      .stat_wr    (stat_wr_1),
      .stat_rd    (stat_rd_1),
      .stat_addr  (stat_addr_1),
      .stat_wdata (stat_wdata_1),
      .stat_ack   (stat_ack_1),
      .stat_rdata (stat_rdata_1),
      .stat_int   (stat_int_1)
    );
  end
  else
  begin : g_chan_b_tie
    assign stat_ack_1   = 1'b1;   // ack forever so the host never waits
    assign stat_rdata_1 = '0;
    assign stat_int_1   = '0;
  end

  // channel D tie-off follows the same rule as an absent B
  assign stat_ack_2   = 1'b1;
  assign stat_rdata_2 = '0;     // requests on D are dropped
  assign stat_int_2   = '0;

endmodule

/* design/cl_reset_sync.sv */
`timescale 1ns/1ps

`include "cl_stat_config.svh"

module cl_reset_sync
(
  input  logic clk,
  input  logic pipe_rst_n,   // already retimed to clk, active low
  output logic sync_rst_n,   // logic reset for the pipes
  output logic chan_rst_n    // late reset for the register blocks
);

  logic pre_sync_rst_n;      // first flop of the pair

  // ----------------------------------------------------------------------------
  // two-flop logic reset
  // ----------------------------------------------------------------------------
  // assert on the first edge that sees pipe_rst_n low,
  // release two edges after it goes high
  always_ff @(posedge clk)
  begin
    if (!pipe_rst_n)
    begin
      pre_sync_rst_n <= 1'b0;
      sync_rst_n     <= 1'b0;
    end
    else
    begin
      pre_sync_rst_n <= 1'b1;
      sync_rst_n     <= pre_sync_rst_n;  // second stage
    end
  end

  // ----------------------------------------------------------------------------
  // staged channel reset
  // ----------------------------------------------------------------------------
  // channel logic comes out of reset after the pipes are already clean
  stat_pipe
  #(
    .WIDTH  (1),
    .STAGES (`RST_PIPE_STAGES)
  )
  u_chan_rst_pipe
  (
    .clk     (clk),
    .clr_n   (1'b1),        // reset path itself never cleared
    .in_bus  (sync_rst_n),
    .out_bus (chan_rst_n)
  );

endmodule

/* design/cl_stat_pkg.sv */
`include "cl_stat_config.svh"

package cl_stat_pkg;

  // ----------------------------------------------------------------------------
  // status address decode
  // ----------------------------------------------------------------------------

  // top two bits select a page, the rest pick a register in it
  typedef struct packed
  {
    logic [1:0]                page;   // 0 cfg/scratch, 1 interrupt
    logic [`STAT_ADDR_W-3:0]   index;  // register within page
  } stat_addr_fields_t;

  // pipes and top carry the raw byte
  // register block looks at the fields
  typedef union packed
  {
    logic [`STAT_ADDR_W-1:0]   raw;
    stat_addr_fields_t         fields;
  } stat_addr_u;

endpackage

/* design/stat_channel.sv */
`timescale 1ns/1ps

`include "cl_stat_config.svh"

module stat_channel
#(
  parameter int CHANNEL = 0
)
(
  input  logic                     clk,
  input  logic                     sync_rst_n,   // clears the pipes
  input  logic                     chan_rst_n,   // resets the register block
  input  logic                     stat_wr,
  input  logic                     stat_rd,
  input  cl_stat_pkg::stat_addr_u  stat_addr,
  input  logic [`STAT_DATA_W-1:0]  stat_wdata,
  output logic                     stat_ack,
  output logic [`STAT_DATA_W-1:0]  stat_rdata,
  output logic [`STAT_INT_W-1:0]   stat_int
);

  // wr + rd + addr + wdata
  localparam int REQ_W = 2 + `STAT_ADDR_W + `STAT_DATA_W;
  // ack + int + rdata
  localparam int RSP_W = 1 + `STAT_INT_W + `STAT_DATA_W;

  // target side of the pipes
  logic                    wr_q;
  logic                    rd_q;
  cl_stat_pkg::stat_addr_u addr_q;
  logic [`STAT_DATA_W-1:0] wdata_q;
  logic                    ack_q;
  logic [`STAT_DATA_W-1:0] rdata_q;
  logic [`STAT_INT_W-1:0]  int_q;

  logic [REQ_W-1:0]        req_bus;
  logic [RSP_W-1:0]        rsp_bus;

  // ----------------------------------------------------------------------------
  // request path, host to register block
  // ----------------------------------------------------------------------------
  stat_pipe
  #(
    .WIDTH  (REQ_W),
    .STAGES (`STAT_REQ_STAGES)
  )
  u_req_pipe
  (
    .clk     (clk),
    .clr_n   (sync_rst_n),
    .in_bus  ({stat_wr, stat_rd, stat_addr, stat_wdata}),
    .out_bus (req_bus)
  );

  assign {wr_q, rd_q, addr_q, wdata_q} = req_bus;   // unpack at the far end

  stat_reg_target
  #(
    .CHANNEL (CHANNEL)
  )
  u_target
  (
    .clk        (clk),
    .rst_n      (chan_rst_n),   // delayed reset
    .stat_wr    (wr_q),
    .stat_rd    (rd_q),
    .stat_addr  (addr_q),
    .stat_wdata (wdata_q),
    .stat_ack   (ack_q),
    .stat_rdata (rdata_q),
    .stat_int   (int_q)
  );

  // ----------------------------------------------------------------------------
  // response path, back to the host
  // ----------------------------------------------------------------------------
  stat_pipe
  #(
    .WIDTH  (RSP_W),
    .STAGES (`STAT_RSP_STAGES)
  )
  u_rsp_pipe
  (
    .clk     (clk),
    .clr_n   (sync_rst_n),
    .in_bus  ({ack_q, int_q, rdata_q}),
    .out_bus (rsp_bus)
  );

  assign {stat_ack, stat_int, stat_rdata} = rsp_bus;

endmodule

/* design/stat_pipe.sv */
`timescale 1ns/1ps

module stat_pipe
#(
  parameter int WIDTH  = 1,   // bus width
  parameter int STAGES = 1    // flop count, at least one
)
(
  input  logic             clk,
  input  logic             clr_n,    // sync clear, empties all stages
  input  logic [WIDTH-1:0] in_bus,
  output logic [WIDTH-1:0] out_bus
);

  // one register per stage, stage 0 nearest the input
  logic [WIDTH-1:0] stage_q [STAGES];

  // ----------------------------------------------------------------------------
  // shift chain
  // ----------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!clr_n)
    begin
      for (int i = 0; i < STAGES; i++)
        stage_q[i] <= '0;       // drop anything in flight
    end
    else
    begin
      stage_q[0] <= in_bus;
      for (int i = 1; i < STAGES; i++)
        stage_q[i] <= stage_q[i-1];  // advance one stage per clock
    end
  end

  // exactly STAGES cycles of latency
  assign out_bus = stage_q[STAGES-1];

endmodule

/* design/stat_reg_target.sv */
`timescale 1ns/1ps

`include "cl_stat_config.svh"

module stat_reg_target
#(
  parameter int CHANNEL = 0    // 0 = A, 1 = B
)
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     stat_wr,
  input  logic                     stat_rd,
  input  cl_stat_pkg::stat_addr_u  stat_addr,
  input  logic [`STAT_DATA_W-1:0]  stat_wdata,
  output logic                     stat_ack,
  output logic [`STAT_DATA_W-1:0]  stat_rdata,
  output logic [`STAT_INT_W-1:0]   stat_int
);

  // ----------------------------------------------------------------------------
  // map constants
  // ----------------------------------------------------------------------------
  localparam int IDX_W     = `STAT_ADDR_W - 2;
  localparam int SCR_SEL_W = $clog2(`STAT_SCRATCH_COUNT + 1);

  localparam logic [1:0]       PAGE_CFG    = 2'd0;   // id + scratch
  localparam logic [1:0]       PAGE_INT    = 2'd1;   // interrupt status
  localparam logic [IDX_W-1:0] IDX_ID      = '0;
  localparam logic [IDX_W-1:0] IDX_INT_SET = IDX_W'(0);
  localparam logic [IDX_W-1:0] IDX_INT_CLR = IDX_W'(1);

  localparam logic [`STAT_DATA_W-1:0] ID_VALUE = `STAT_ID_BASE + 32'(CHANNEL);

  // ----------------------------------------------------------------------------
  // state
  // ----------------------------------------------------------------------------
  logic [`STAT_DATA_W-1:0] scratch_q [1:`STAT_SCRATCH_COUNT];
  logic [`STAT_INT_W-1:0]  int_q;       // pending interrupt bits
  logic                    ack_q;
  logic [`STAT_DATA_W-1:0] rdata_q;

  // decode
  logic [1:0]              page;
  logic [IDX_W-1:0]        index;
  logic [SCR_SEL_W-1:0]    scr_sel;
  logic                    scr_hit;
  logic [`STAT_DATA_W-1:0] rd_value;

  assign page    = stat_addr.fields.page;
  assign index   = stat_addr.fields.index;
  assign scr_sel = index[SCR_SEL_W-1:0];
  // index 0 of page 0 is the id, not scratch
  assign scr_hit = (page == PAGE_CFG) && (index != '0) &&
                   (index <= IDX_W'(`STAT_SCRATCH_COUNT));

  // ----------------------------------------------------------------------------
  // read mux
  // ----------------------------------------------------------------------------
  always_comb
  begin
    rd_value = '0;                          // unmapped reads zero
    if (scr_hit)
      rd_value = scratch_q[scr_sel];
    else if ((page == PAGE_CFG) && (index == IDX_ID))
      rd_value = ID_VALUE;
    else if ((page == PAGE_INT) &&
             ((index == IDX_INT_SET) || (index == IDX_INT_CLR)))
      rd_value = `STAT_DATA_W'(int_q);      // both views return status
  end

  // ----------------------------------------------------------------------------
  // writes
  // ----------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i <= `STAT_SCRATCH_COUNT; i++)
        scratch_q[i] <= '0;
      int_q <= '0;
    end
    else if (stat_wr)
    begin
      if (scr_hit)
        scratch_q[scr_sel] <= stat_wdata;
      else if ((page == PAGE_INT) && (index == IDX_INT_SET))
        int_q <= int_q | stat_wdata[`STAT_INT_W-1:0];     // set on 1
      else if ((page == PAGE_INT) && (index == IDX_INT_CLR))
        int_q <= int_q & ~stat_wdata[`STAT_INT_W-1:0];    // clear on 1
      // id and unmapped writes dropped
    end
  end

  // ----------------------------------------------------------------------------
  // response, one cycle after the strobe
  // ----------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end
    else
    begin
      ack_q   <= stat_wr | stat_rd;             // one ack per strobe
      rdata_q <= stat_rd ? rd_value : '0;       // zero on write acks
    end
  end

  assign stat_ack   = ack_q;
  assign stat_rdata = rdata_q;
  assign stat_int   = int_q;   // level, straight from status

endmodule

/* include/cl_stat_config.svh */
`ifndef CL_STAT_CONFIG_SVH
`define CL_STAT_CONFIG_SVH

// ----------------------------------------------------------------------------
// status bus widths
// ----------------------------------------------------------------------------
`define STAT_ADDR_W 8          // page + index
`define STAT_DATA_W 32
`define STAT_INT_W 8           // per-channel interrupt vector

// ----------------------------------------------------------------------------
// retiming depths
// ----------------------------------------------------------------------------
`define STAT_REQ_STAGES 8      // host to register block
`define STAT_RSP_STAGES 8      // register block back to host
`define RST_PIPE_STAGES 4      // extra delay on the channel reset

// register map sizing
`define STAT_SCRATCH_COUNT 15  // page 0, indices 1..15

// id register reads base + channel number
`define STAT_ID_BASE 32'h5354_0000

// ----------------------------------------------------------------------------
// channel presence
// ----------------------------------------------------------------------------
// 0 ties channel B off the same way as D
`define DDR_B_PRESENT 1

`endif

/* sim.f */
+incdir+include
design/cl_stat_pkg.sv
design/stat_pipe.sv
design/cl_reset_sync.sv
design/stat_reg_target.sv
design/stat_channel.sv
design/awsf1_cl_stat.sv
testbench/tb_awsf1_cl_stat.sv

/* testbench/tb_awsf1_cl_stat.sv */
`timescale 1ns/1ps

`include "cl_stat_config.svh"

module tb_awsf1_cl_stat;

  // strobe to ack through req pipe + target + rsp pipe
  localparam int LATENCY = `STAT_REQ_STAGES + 1 + `STAT_RSP_STAGES;
  // whole run takes roughly 310 cycles
  localparam int TIMEOUT_CYCLES = 2000;

  logic                    clk;
  logic                    pipe_rst_n;
  logic                    checks_on;    // assertions armed after reset settles

  // host side per channel index (0 = A, 1 = B, 2 = D)
  logic                    wr    [3];
  logic                    rd    [3];
  cl_stat_pkg::stat_addr_u addr  [3];
  logic [`STAT_DATA_W-1:0] wdata [3];
  logic                    ack   [3];
  logic [`STAT_DATA_W-1:0] rdata [3];
  logic [`STAT_INT_W-1:0]  intr  [3];

  // reference model for the present channels only
  logic [`STAT_DATA_W-1:0] model_scr [2][16];   // index 0 unused
  logic [`STAT_INT_W-1:0]  model_int [2];
  logic [`STAT_DATA_W-1:0] exp_rdata [2];       // set with each read strobe

  integer                  seed;
  int                      cycle_count;

  awsf1_cl_stat DUT
  (
    .clk_main_a0  (clk),
    .pipe_rst_n   (pipe_rst_n),
    .stat_wr_0    (wr[0]),
    .stat_rd_0    (rd[0]),
    .stat_addr_0  (addr[0]),
    .stat_wdata_0 (wdata[0]),
    .stat_ack_0   (ack[0]),
    .stat_rdata_0 (rdata[0]),
    .stat_int_0   (intr[0]),
    .stat_wr_1    (wr[1]),
    .stat_rd_1    (rd[1]),
    .stat_addr_1  (addr[1]),
    .stat_wdata_1 (wdata[1]),
    .stat_ack_1   (ack[1]),
    .stat_rdata_1 (rdata[1]),
    .stat_int_1   (intr[1]),
    .stat_wr_2    (wr[2]),
    .stat_rd_2    (rd[2]),
    .stat_addr_2  (addr[2]),
    .stat_wdata_2 (wdata[2]),
    .stat_ack_2   (ack[2]),
    .stat_rdata_2 (rdata[2]),
    .stat_int_2   (intr[2])
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  // --------------------------------------------------------------------------
  // model helpers
  // --------------------------------------------------------------------------
  function automatic logic [`STAT_DATA_W-1:0] expected_read(input int ch,
                                                          input cl_stat_pkg::stat_addr_u a);
    logic [`STAT_DATA_W-1:0] value;
    value = '0;   // unmapped
    if (a.fields.page == 2'd0 && a.fields.index == 6'd0)
      value = `STAT_ID_BASE + ch;
    else if (a.fields.page == 2'd0 && a.fields.index <= `STAT_SCRATCH_COUNT)
      value = model_scr[ch][a.fields.index];
    else if (a.fields.page == 2'd1 && a.fields.index <= 6'd1)
      value = {{(`STAT_DATA_W-`STAT_INT_W){1'b0}}, model_int[ch]};   // set/clr views
    return value;
  endfunction

  task automatic apply_write(input int ch, input cl_stat_pkg::stat_addr_u a,
                             input logic [`STAT_DATA_W-1:0] data);
    if (a.fields.page == 2'd0 && a.fields.index != 6'd0 &&
        a.fields.index <= `STAT_SCRATCH_COUNT)
      model_scr[ch][a.fields.index] = data;
    else if (a.fields.page == 2'd1 && a.fields.index == 6'd0)
      model_int[ch] = model_int[ch] | data[`STAT_INT_W-1:0];    // set on 1
    else if (a.fields.page == 2'd1 && a.fields.index == 6'd1)
      model_int[ch] = model_int[ch] & ~data[`STAT_INT_W-1:0];   // clear on 1
  endtask

  // --------------------------------------------------------------------------
  // host drive 1 ns after the rising edge
  // --------------------------------------------------------------------------
  task automatic clear_strobes();
    for (int c = 0; c < 3; c++)
    begin
      wr[c] = 1'b0;
      rd[c] = 1'b0;
    end
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
      clear_strobes();
    end
  endtask

  task automatic send_request(input int ch, input bit is_wr, input int page, input int index,
                              input logic [`STAT_DATA_W-1:0] data);
    cl_stat_pkg::stat_addr_u a;
    a.fields.page  = page[1:0];
    a.fields.index = index[5:0];
    @(posedge clk);
    #1;
    clear_strobes();      // strobes last one cycle
    addr[ch]  = a;
    wdata[ch] = data;
    wr[ch]    = is_wr;
    rd[ch]    = !is_wr;
    if (ch < 2)
    begin
      if (is_wr)
        apply_write(ch, a, data);
      else
        exp_rdata[ch] = expected_read(ch, a);
    end
  endtask

  task automatic report_mismatch(input string msg);
    $display("MISMATCH @ %0t ns: %s", $time, msg);
    $display(">>> FAIL");
  endtask

  // --------------------------------------------------------------------------
  // checks on A and B
  // --------------------------------------------------------------------------
  for (genvar c = 0; c < 2; c++)
  begin : g_check
    ack_after_strobe: assert property (@(posedge clk) disable iff (!checks_on)
      $past(wr[c] | rd[c], LATENCY) |-> ack[c])
    else
    begin
      report_mismatch($sformatf("ch %0d no ack %0d cycles after strobe", c, LATENCY));
      $fatal(1);
    end

    // ack must be a clean low whenever no strobe is due
    no_stray_ack: assert property (@(posedge clk) disable iff (!checks_on)
      !$past(wr[c] | rd[c], LATENCY) |-> !ack[c])
    else
    begin
      report_mismatch($sformatf("ch %0d ack without a matching strobe", c));
      $fatal(1);
    end

    read_data: assert property (@(posedge clk) disable iff (!checks_on)
      (ack[c] && $past(rd[c], LATENCY)) |-> rdata[c] == $past(exp_rdata[c], LATENCY))
    else
    begin
      report_mismatch($sformatf("ch %0d read data %h differs from model", c, rdata[c]));
      $fatal(1);
    end

    // status change shows up 17 cycles after the write strobe
    int_level: assert property (@(posedge clk) disable iff (!checks_on)
      intr[c] == $past(model_int[c], LATENCY))
    else
    begin
      report_mismatch($sformatf("ch %0d stat_int %h differs from model", c, intr[c]));
      $fatal(1);
    end
  end

  // absent D acks forever with zero data
  tie_off_d: assert property (@(posedge clk) disable iff (!checks_on)
    ack[2] && rdata[2] == '0 && intr[2] == '0)
  else
  begin
    report_mismatch("channel D tie-off not holding ack high with zero data");
    $fatal(1);
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display(">>> FAIL");
    $fatal(1);
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial
  begin
    seed         = 55;
    pipe_rst_n   = 1'b0;
    checks_on    = 1'b0;
    for (int c = 0; c < 3; c++)
    begin
      wr[c]    = 1'b0;
      rd[c]    = 1'b0;
      addr[c]  = '0;
      wdata[c] = '0;
    end
    for (int c = 0; c < 2; c++)
    begin
      model_int[c] = '0;
      exp_rdata[c] = '0;
      for (int i = 0; i < 16; i++)
        model_scr[c][i] = '0;
    end

    repeat (5) @(posedge clk);
    #1;
    pipe_rst_n = 1'b1;
    idle(20);             // well past the 8 cycle host wait
    checks_on = 1'b1;
    idle(4);              // idle outputs and D tie-off

    // scratch write then read back
    for (int ch = 0; ch < 2; ch++)
    begin
      send_request(ch, 1'b1, 0, 3, $random(seed));
      send_request(ch, 1'b0, 0, 3, '0);
    end
    idle(20);

    // id is read-only and unmapped reads return zero
    for (int ch = 0; ch < 2; ch++)
    begin
      send_request(ch, 1'b0, 0, 0, '0);
      send_request(ch, 1'b1, 0, 0, $random(seed));
      send_request(ch, 1'b0, 0, 0, '0);
      send_request(ch, 1'b0, 0, 16, '0);
      send_request(ch, 1'b0, 0, 63, '0);
      send_request(ch, 1'b0, 1, 2, '0);
      send_request(ch, 1'b1, 2, 0, $random(seed));
      send_request(ch, 1'b0, 2, 0, '0);
      send_request(ch, 1'b0, 3, 5, '0);
    end
    send_request(2, 1'b1, 0, 1, $random(seed));   // D swallows these
    send_request(2, 1'b0, 0, 1, '0);
    idle(20);

    // interrupt set and clear with upper data bits ignored
    for (int ch = 0; ch < 2; ch++)
    begin
      send_request(ch, 1'b1, 1, 0, 32'hFFFF_FFA5);
      send_request(ch, 1'b0, 1, 0, '0);
      idle(20);
      send_request(ch, 1'b1, 1, 1, 32'hFFFF_FF21);
      send_request(ch, 1'b0, 1, 1, '0);
      idle(20);
      send_request(ch, 1'b1, 1, 0, 32'h0000_005A);
      send_request(ch, 1'b1, 1, 1, 32'h0000_00C3);
      send_request(ch, 1'b0, 1, 0, '0);
      idle(20);
    end

    // back-to-back burst with A and B interleaved
    for (int i = 1; i <= `STAT_SCRATCH_COUNT; i++)
    begin
      send_request(0, 1'b1, 0, i, $random(seed));
      send_request(1, 1'b1, 0, i, $random(seed));
    end
    for (int i = 1; i <= `STAT_SCRATCH_COUNT; i++)
    begin
      send_request(0, 1'b0, 0, i, '0);
      send_request(1, 1'b0, 0, i, '0);
    end
    idle(LATENCY + 8);    // drain both pipes

    $display(">>> PASS");
    $finish;
  end

endmodule
